//--- verilog/ternary_pkg.sv
// Ternary ALU package with trit encoding, word types, operation codes and result types
`default_nettype none

package ternary_pkg;

  //////////////////////////////////////////////////
  // Trit encoding
  //////////////////////////////////////////////////

  typedef logic [1:0] trit_t;

  localparam trit_t TRIT_NEG  = 2'b10;
  localparam trit_t TRIT_ZERO = 2'b00;
  localparam trit_t TRIT_POS  = 2'b01;
  // Never produced by the datapath
  localparam trit_t TRIT_BAD  = 2'b11;

  // 16 trits, 32 bits
  localparam int DEFAULT_NUM_TRITS = 16;

  // Least significant trit at index 0
  typedef trit_t [DEFAULT_NUM_TRITS-1:0] ternary_word_t;

  typedef enum logic [2:0] {
    OP_NEG = 3'd0,
    OP_MIN = 3'd1,
    OP_MAX = 3'd2,
    OP_ADD = 3'd3,
    OP_SUB = 3'd4,
    OP_INC = 3'd5,
    OP_CMP = 3'd6
  } alu_op_t;

  typedef struct packed {
    ternary_word_t a;
    ternary_word_t b;
  } alu_request_t;

  // Flag is the carry for add/sub/inc and the ordering for compare
  typedef struct packed {
    ternary_word_t value;
    trit_t         flag;
  } alu_result_t;

  typedef struct packed {
    logic    write;
    alu_op_t op;
  } alu_cfg_t;

  //////////////////////////////////////////////////
  // Trit value conversion
  //////////////////////////////////////////////////

  // Illegal code reads as zero
  function automatic int trit_value(trit_t t);
    case (t)
      TRIT_NEG: return -1;
      TRIT_POS: return 1;
      default:  return 0;
    endcase
  endfunction

  // Sign of an integer as a trit
  function automatic trit_t to_trit(int v);
    if (v > 0) return TRIT_POS;
    if (v < 0) return TRIT_NEG;
    return TRIT_ZERO;
  endfunction

endpackage

`default_nettype wire

//--- verilog/trit_logic_unit.sv
// Trit-wise negation, minimum and maximum over a ternary word
`timescale 1ns/10ps
`default_nettype none

module trit_logic_unit
  import ternary_pkg::*;
#(
  parameter int num_trits = DEFAULT_NUM_TRITS
) (
  input  trit_t [num_trits-1:0] a,
  input  trit_t [num_trits-1:0] b,
  output trit_t [num_trits-1:0] neg_a,
  output trit_t [num_trits-1:0] min_ab,
  output trit_t [num_trits-1:0] max_ab
);

  //////////////////////////////////////////////////
  // Negation
  //////////////////////////////////////////////////

  // Swapping the two bits maps - to + and leaves 0 alone
  always_comb begin
    for (int i = 0; i < num_trits; i++) begin
      neg_a[i] = {a[i][0], a[i][1]};
    end
  end

  //////////////////////////////////////////////////
  // Minimum and maximum
  //////////////////////////////////////////////////

  // Order is - < 0 < +
  always_comb begin
    for (int i = 0; i < num_trits; i++) begin
      if (trit_value(a[i]) < trit_value(b[i])) begin
        min_ab[i] = a[i];
      end else begin
        min_ab[i] = b[i];
      end

      if (trit_value(a[i]) > trit_value(b[i])) begin
        max_ab[i] = a[i];
      end else begin
        max_ab[i] = b[i];
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/ternary_adder.sv
// Balanced-ternary ripple adder with carry-in and carry-out trits
`timescale 1ns/10ps
`default_nettype none

module ternary_adder
  import ternary_pkg::*;
#(
  parameter int num_trits = DEFAULT_NUM_TRITS
) (
  input  trit_t [num_trits-1:0] a,
  input  trit_t [num_trits-1:0] b,
  input  trit_t                 carry_in,
  output trit_t [num_trits-1:0] sum,
  output trit_t                 carry_out
);

  //////////////////////////////////////////////////
  // Full-adder chain
  //////////////////////////////////////////////////

  // Each stage sees a+b+c in -3..3 and splits it into
  // total = 3*carry + digit with digit in -1..1
  //
  //   total  -3 -2 -1  0  1  2  3
  //   carry   -  -  0  0  0  +  +
  //   digit   0  +  -  0  +  -  0
  always_comb begin
    trit_t carry;
    int    total;
    int    carry_val;

    carry = carry_in;
    for (int i = 0; i < num_trits; i++) begin
      total = trit_value(a[i]) + trit_value(b[i]) + trit_value(carry);

      if (total > 1) begin
        carry_val = 1;
      end else if (total < -1) begin
        carry_val = -1;
      end else begin
        carry_val = 0;
      end

      sum[i] = to_trit(total - 3 * carry_val);
      // Ripple into the next stage
      carry  = to_trit(carry_val);
    end

    carry_out = carry;
  end

endmodule

`default_nettype wire

//--- verilog/ternary_comparator.sv
// Signed balanced-ternary compare reduced by a pairwise tree to one ordering trit
`timescale 1ns/10ps
`default_nettype none

module ternary_comparator
  import ternary_pkg::*;
#(
  parameter int num_trits = DEFAULT_NUM_TRITS
) (
  input  trit_t [num_trits-1:0] a,
  input  trit_t [num_trits-1:0] b,
  output trit_t                 order
);

  localparam int levels = $clog2(num_trits);

  // Pairwise tree needs a full binary shape
  if ((num_trits & (num_trits - 1)) != 0) begin : g_size_check
    $error("ternary_comparator: num_trits must be a power of two");
  end

  //////////////////////////////////////////////////
  // Reduction tree
  //////////////////////////////////////////////////

  // Level 0 holds one ordering trit per position,
  // each higher level halves the count
  for (genvar l = 0; l <= levels; l++) begin : g_level
    trit_t node [num_trits >> l];

    if (l == 0) begin : g_leaf
      // - for a<b, 0 for equal, + for a>b
      for (genvar i = 0; i < num_trits; i++) begin : g_trit
        assign node[i] = to_trit(trit_value(a[i]) - trit_value(b[i]));
      end
    end else begin : g_pair
      // Upper trit decides unless it is equal
      for (genvar i = 0; i < (num_trits >> l); i++) begin : g_node
        assign node[i] = (g_level[l-1].node[2*i+1] != TRIT_ZERO) ?
                         g_level[l-1].node[2*i+1] : g_level[l-1].node[2*i];
      end
    end
  end

  assign order = g_level[levels].node[0];

endmodule

`default_nettype wire

//--- verilog/alu_config.sv
// Operation register loaded from the configuration port
`timescale 1ns/10ps
`default_nettype none

module alu_config
  import ternary_pkg::*;
(
  input  logic     clk,
  input  logic     reset,
  input  alu_cfg_t cfg,
  output alu_op_t  op
);

  alu_op_t op_q;

  // Add is the default after reset
  always_ff @(posedge clk) begin
    if (reset) begin
      op_q <= OP_ADD;
    end else if (cfg.write) begin
      op_q <= cfg.op;
    end
  end

  assign op = op_q;

  // Code 7 has no operation behind it
  a_cfg_op_legal: assert property (
    @(posedge clk) disable iff (reset)
    cfg.write |-> cfg.op inside {OP_NEG, OP_MIN, OP_MAX, OP_ADD, OP_SUB, OP_INC, OP_CMP}
  ) else $error("alu_config: undefined op code %0d written", cfg.op);

endmodule

`default_nettype wire

//--- verilog/ternary_exec.sv
// Execution block with req/ack handshake, operand routing, result select and result register
`timescale 1ns/10ps
`default_nettype none

module ternary_exec
  import ternary_pkg::*;
#(
  parameter int num_trits = DEFAULT_NUM_TRITS
) (
  input  logic         clk,
  input  logic         reset,
  input  alu_op_t      op,
  input  logic         req,
  input  alu_request_t operands,
  output logic         ack,
  output alu_result_t  result
);

  typedef trit_t [num_trits-1:0] trits_t;

  trits_t      a_w, b_w, neg_a, neg_b, min_ab, max_ab, add_b, sum;
  trit_t       add_cin, add_cout, order;
  alu_result_t result_d, result_q;
  logic        ack_q;
  logic        start;

  if (num_trits > DEFAULT_NUM_TRITS) begin : g_size_check
    $error("ternary_exec: num_trits exceeds the word type");
  end

  assign a_w = operands.a[num_trits-1:0];
  assign b_w = operands.b[num_trits-1:0];

  trit_logic_unit #(.num_trits(num_trits)) logic_a_i (
    .a(a_w), .b(b_w), .neg_a(neg_a), .min_ab(min_ab), .max_ab(max_ab)
  );

  // Second unit only supplies -b for subtraction
  trit_logic_unit #(.num_trits(num_trits)) logic_b_i (
    .a(b_w), .b(a_w), .neg_a(neg_b), .min_ab(), .max_ab()
  );

  ternary_adder #(.num_trits(num_trits)) adder_i (
    .a(a_w), .b(add_b), .carry_in(add_cin), .sum(sum), .carry_out(add_cout)
  );

  ternary_comparator #(.num_trits(num_trits)) cmp_i (
    .a(a_w), .b(b_w), .order(order)
  );

  //////////////////////////////////////////////////
  // Adder routing and result select
  //////////////////////////////////////////////////

  // a-b is a+(-b), a+1 is a+0 with carry-in +
  always_comb begin
    add_b   = b_w;
    add_cin = TRIT_ZERO;
    if (op == OP_SUB) add_b = neg_b;
    if (op == OP_INC) begin
      add_b   = {num_trits{TRIT_ZERO}};
      add_cin = TRIT_POS;
    end
  end

  always_comb begin
    result_d = '0;
    case (op)
      OP_NEG:                 result_d.value[num_trits-1:0] = neg_a;
      OP_MIN:                 result_d.value[num_trits-1:0] = min_ab;
      OP_MAX:                 result_d.value[num_trits-1:0] = max_ab;
      OP_ADD, OP_SUB, OP_INC: begin
        result_d.value[num_trits-1:0] = sum;
        result_d.flag                 = add_cout;
      end
      OP_CMP:                 result_d.flag = order;
      default:                result_d = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Four-phase handshake
  //////////////////////////////////////////////////

  assign start = req && !ack_q;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack_q    <= 1'b0;
      result_q <= '0;
    end else if (start) begin
      ack_q    <= 1'b1;
      result_q <= result_d;
    end else if (!req) begin
      ack_q <= 1'b0;
    end
  end

  assign ack    = ack_q;
  assign result = result_q;

  function automatic logic has_bad(trits_t w);
    for (int i = 0; i < num_trits; i++) if (w[i] == TRIT_BAD) return 1'b1;
    return 1'b0;
  endfunction

  // Request may only be withdrawn once it was acknowledged
  a_req_held: assert property (@(posedge clk) disable iff (reset) $fell(req) |-> ack_q)
    else $error("ternary_exec: req dropped before ack");
  a_operands_legal: assert property (@(posedge clk) disable iff (reset)
    req |-> !has_bad(a_w) && !has_bad(b_w)) else $error("ternary_exec: illegal operand trit");
  a_result_legal: assert property (@(posedge clk) disable iff (reset)
    ack_q |-> !has_bad(result_q.value[num_trits-1:0]) && result_q.flag != TRIT_BAD)
    else $error("ternary_exec: illegal result trit");

endmodule

`default_nettype wire

//--- verilog/ternary_alu.sv
// Ternary ALU top level joining the operation register and the execution block
`timescale 1ns/10ps
`default_nettype none

module ternary_alu
  import ternary_pkg::*;
#(
  parameter int num_trits = DEFAULT_NUM_TRITS
) (
  input  logic         clk,
  input  logic         reset,
  input  alu_cfg_t     cfg,
  input  logic         req,
  input  alu_request_t operands,
  output logic         ack,
  output alu_result_t  result
);

  // Selected operation, steers the execution block
  alu_op_t op;

  alu_config cfg_i (
    .clk  (clk),
    .reset(reset),
    .cfg  (cfg),
    .op   (op)
  );

  ternary_exec #(
    .num_trits(num_trits)
  ) exec_i (
    .clk     (clk),
    .reset   (reset),
    .op      (op),
    .req     (req),
    .operands(operands),
    .ack     (ack),
    .result  (result)
  );

endmodule

`default_nettype wire

//--- testbench/ternary_alu_tb.sv
// Testbench for the ternary ALU, driven by a case file through the req/ack handshake
`timescale 1ns/10ps
`default_nettype none

module ternary_alu_tb
  import ternary_pkg::*;
();

  localparam string CASE_FILE = "testbench/ternary_alu_cases.txt";
  localparam int    MAX_CASES = 64;

  logic         clk = 1'b0;
  logic         reset;
  alu_cfg_t     cfg;
  logic         req;
  alu_request_t operands;
  logic         ack;
  alu_result_t  result;

  alu_op_t       case_op    [MAX_CASES];
  ternary_word_t case_a     [MAX_CASES];
  ternary_word_t case_b     [MAX_CASES];
  ternary_word_t case_value [MAX_CASES];
  trit_t         case_flag  [MAX_CASES];
  int            num_cases = 0;
  logic          loaded = 1'b0;

  logic [31:0]   lfsr_state = 32'hd943ef55;
  logic          ack_last = 1'b0;
  logic          req_last = 1'b0;
  alu_result_t   result_last = '0;

  ternary_alu dut_i (
    .clk     (clk),
    .reset   (reset),
    .cfg     (cfg),
    .req     (req),
    .operands(operands),
    .ack     (ack),
    .result  (result)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic abort_run(input string reason);
    if (reason.len() > 0) $display("Error: %s", reason);
    $display("TESTS FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_word(input string name, input ternary_word_t expected,
                            input ternary_word_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h, got %h", name, expected, actual);
      abort_run("");
    end
  endtask

  task automatic check_trit(input string name, input trit_t expected, input trit_t actual);
    if (actual !== expected) begin
      $display("** Error: %s expected %h, got %h", name, expected, actual);
      abort_run("");
    end
  endtask

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  // Two bits give 0 to 3 cycles
  task automatic random_cycles(output int n);
    n = 0;
    for (int i = 0; i < 2; i++) begin
      n = 2 * n + int'(lfsr_state[31]);
      lfsr_state = lfsr_step(lfsr_state);
    end
  endtask

  // Inputs change 1 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic load_cases();
    string       line;
    int          fd;
    logic [31:0] op_v, a_v, b_v, value_v, flag_v;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) abort_run("could not open the case file");
    while ($fgets(line, fd) != 0) begin
      // Comment and blank lines match nothing
      if ($sscanf(line, "%h %h %h %h %h", op_v, a_v, b_v, value_v, flag_v) == 5) begin
        if (num_cases >= MAX_CASES) abort_run("the case file holds too many cases");
        case_op[num_cases]    = alu_op_t'(op_v[2:0]);
        case_a[num_cases]     = a_v;
        case_b[num_cases]     = b_v;
        case_value[num_cases] = value_v;
        case_flag[num_cases]  = flag_v[1:0];
        num_cases++;
      end
    end
    $fclose(fd);
    if (num_cases == 0) abort_run("the case file holds no cases");
  endtask

  task automatic write_op(input alu_op_t op);
    cfg.write = 1'b1;
    cfg.op    = op;
    next_cycle();
    cfg.write = 1'b0;
  endtask

  task automatic run_case(input int idx);
    int idle;
    int hold;
    random_cycles(idle);
    random_cycles(hold);
    repeat (idle) next_cycle();
    operands.a = case_a[idx];
    operands.b = case_b[idx];
    req        = 1'b1;
    do next_cycle(); while (!ack);
    check_word($sformatf("result.value (case %0d)", idx), case_value[idx], result.value);
    check_trit($sformatf("result.flag (case %0d)", idx), case_flag[idx], result.flag);
    // Held req, ack and result must stay put
    repeat (hold) next_cycle();
    req = 1'b0;
    do next_cycle(); while (ack);
  endtask

  //////////////////////////////////////////////////
  // Handshake monitor
  //////////////////////////////////////////////////

  // Sampled mid-cycle and compared against the previous sample
  always @(negedge clk) begin
    if (!reset) begin
      if (ack && !ack_last && !req_last) abort_run("ack rose without a request");
      if (!ack && !ack_last && req_last) abort_run("ack did not rise one cycle after req");
      if (ack && ack_last && !req_last) abort_run("ack did not fall after req was released");
      if (!ack && ack_last && req_last) abort_run("ack fell while req was still high");
      if (ack && ack_last && result !== result_last) abort_run("result changed while ack was high");
    end
    ack_last    <= ack;
    req_last    <= req;
    result_last <= result;
  end

  // Twelve cycles per case plus margin
  initial begin
    wait (loaded);
    repeat (num_cases * 12 + 100) @(posedge clk);
    abort_run($sformatf("run timed out after %0d cycles", num_cases * 12 + 100));
  end

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    reset    = 1'b1;
    cfg      = '0;
    req      = 1'b0;
    operands = '0;
    load_cases();
    loaded = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    reset = 1'b0;
    if (ack !== 1'b0) abort_run("ack is not low after reset");
    check_word("result.value after reset", '0, result.value);
    check_trit("result.flag after reset", TRIT_ZERO, result.flag);

    for (int i = 0; i < num_cases; i++) begin
      // A leading add relies on the reset op
      if (i > 0 || case_op[i] != OP_ADD) write_op(case_op[i]);
      run_case(i);
    end

    $display("TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/ternary_alu_cases.txt
# op a b value flag, all hex, trits 2 bits each (- 10, 0 00, + 01)
# op: 0 neg, 1 min, 2 max, 3 add, 4 sub, 5 inc, 6 cmp
3 00000001 00000001 00000006 0
3 00000005 00000001 0000001A 0
3 00000004 00000009 00000001 0
3 55555555 00000001 AAAAAAAA 1
3 AAAAAAAA 00000002 55555555 2
3 55555555 55555555 00000002 1
3 A8056606 540A9909 00000000 0
0 5A690812 00000000 A5960421 0
0 00000000 00000000 00000000 0
0 55555555 00000000 AAAAAAAA 0
1 A8056606 86185862 AA086A22 0
1 86185862 A8056606 AA086A22 0
1 00000000 55555555 00000000 0
2 A8056606 86185862 84155446 0
2 86185862 A8056606 84155446 0
2 00000000 AAAAAAAA 00000000 0
4 00000001 00000006 00000002 0
4 00000000 00000000 00000000 0
4 AAAAAAAA 00000001 55555555 2
4 55555555 00000002 AAAAAAAA 1
4 A8056606 A8056606 00000000 0
4 0000001A 00000010 0000000A 0
5 55555555 00000000 AAAAAAAA 1
5 00000000 00000000 00000001 0
5 00000001 00000000 00000006 0
5 AAAAAAAA 00000000 AAAAAAA8 0
5 0000000A 00000000 00000008 0
5 00000016 00000000 00000014 0
6 A8056606 A8056606 00000000 0
6 00000001 00000000 00000000 1
6 00000000 00000001 00000000 2
6 A8056606 A8056605 00000000 2
6 A8056605 A8056606 00000000 1
6 55555555 AAAAAAAA 00000000 1
6 10000000 05555555 00000000 1
6 20000000 0AAAAAAA 00000000 2

//--- sim.f
verilog/ternary_pkg.sv
verilog/trit_logic_unit.sv
verilog/ternary_adder.sv
verilog/ternary_comparator.sv
verilog/alu_config.sv
verilog/ternary_exec.sv
verilog/ternary_alu.sv
testbench/ternary_alu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the ternary ALU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
  --top-module ternary_alu_tb -f sim.f \
  -Mdir obj_dir -o ternary_alu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/ternary_alu_sim
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0
